// File: mips_exec.f
+incdir+testbench
common/exec_pkg.sv
common/exec_bus_if.sv
logic/instr_decoder.sv
alu/alu.sv
logic/hilo_unit.sv
logic/exec_writeback.sv
logic/exec_unit.sv
testbench/tb_exec_unit.sv

// File: Makefile
TOP := tb_exec_unit

.PHONY: compile run clean

compile:
	verilator --binary -f mips_exec.f --top-module $(TOP) -o $(TOP)

# Pass only when the simulation prints the pass message
run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "No errors"

clean:
	rm -rf obj_dir

// File: testbench/exec_ref_model.svh
`ifndef EXEC_REF_MODEL_SVH
`define EXEC_REF_MODEL_SVH

typedef struct packed {
    word_t       result;
    logic        wr_en;
    reg_idx_t    wr_reg;
    logic        ovf;
    logic        chk_res;  // Compare result
    logic        chk_reg;  // Compare destination
    logic [31:0] issued;   // Cycle of issue
} exp_t;

// Next state of a 32-bit xorshift generator
function automatic word_t xorshift32(input word_t x);
    word_t s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

// Expected outputs of one instruction with the HI/LO model updated in issue order
function automatic exp_t ref_execute(input instr_t ins, input word_t a, input word_t b,
                                     input word_t pc, inout word_t hi, inout word_t lo);
    exp_t  e;
    word_t sext;
    word_t zext;
    logic  silent;   // No result to compare
    logic  unknown;  // Destination not defined
    e        = '0;
    silent   = 1'b0;
    unknown  = 1'b0;
    sext     = {{16{ins[15]}}, ins[15:0]};
    zext     = {16'h0000, ins[15:0]};
    e.wr_reg = ins[20:16];
    case (ins[31:26])
        OPC_SPECIAL: begin
            e.wr_reg = ins[15:11];
            case (ins[5:0])
                FN_ADD: begin
                    e.result = a + b;
                    e.ovf    = (a[31] == b[31]) && (e.result[31] != a[31]);
                end
                FN_ADDU:  e.result = a + b;
                FN_SUB: begin
                    e.result = a - b;
                    e.ovf    = (a[31] != b[31]) && (e.result[31] != a[31]);
                end
                FN_SUBU:  e.result = a - b;
                FN_AND:   e.result = a & b;
                FN_OR:    e.result = a | b;
                FN_XOR:   e.result = a ^ b;
                FN_NOR:   e.result = ~(a | b);
                FN_SLL:   e.result = b << ins[10:6];
                FN_SRL:   e.result = b >> ins[10:6];
                FN_SRA:   e.result = $signed(b) >>> ins[10:6];
                FN_SLLV:  e.result = b << a[4:0];
                FN_SRLV:  e.result = b >> a[4:0];
                FN_SRAV:  e.result = $signed(b) >>> a[4:0];
                FN_SLT:   e.result = {31'd0, $signed(a) < $signed(b)};
                FN_SLTU:  e.result = {31'd0, a < b};
                FN_MFHI:  e.result = hi;
                FN_MFLO:  e.result = lo;
                FN_MULT: begin
                    {hi, lo} = 64'($signed(a)) * 64'($signed(b));
                    e.wr_reg = '0;
                    silent   = 1'b1;
                end
                FN_MULTU: begin
                    {hi, lo} = 64'(a) * 64'(b);
                    e.wr_reg = '0;
                    silent   = 1'b1;
                end
                FN_MTHI: begin
                    hi       = a;
                    e.wr_reg = '0;
                    silent   = 1'b1;
                end
                FN_MTLO: begin
                    lo       = a;
                    e.wr_reg = '0;
                    silent   = 1'b1;
                end
                default: begin
                    silent  = 1'b1;
                    unknown = 1'b1;
                end
            endcase
        end
        OPC_ADDI: begin
            e.result = a + sext;
            e.ovf    = (a[31] == sext[31]) && (e.result[31] != a[31]);
        end
        OPC_ADDIU: e.result = a + sext;
        OPC_SLTI:  e.result = {31'd0, $signed(a) < $signed(sext)};
        OPC_SLTIU: e.result = {31'd0, a < sext};
        OPC_ANDI:  e.result = a & zext;
        OPC_ORI:   e.result = a | zext;
        OPC_XORI:  e.result = a ^ zext;
        OPC_LUI:   e.result = {ins[15:0], 16'h0000};
        OPC_LW:    e.result = a + sext;
        OPC_SW: begin
            e.result = a + sext;  // Address only
            e.wr_reg = '0;
        end
        OPC_JAL: begin
            e.result = pc + 32'd8;
            e.wr_reg = LINK_REG;
        end
        default: begin
            silent  = 1'b1;
            unknown = 1'b1;
        end
    endcase
    e.chk_res = !silent;
    e.chk_reg = !unknown;
    e.wr_en   = !silent && !e.ovf && (ins[31:26] != OPC_SW);
    return e;
endfunction

`endif

// File: testbench/tb_exec_unit.sv
`timescale 1ns/10ps
`default_nettype none

module tb_exec_unit;
    import exec_pkg::*;

    `include "exec_ref_model.svh"

    // Random issue counts per test
    localparam int R_ARITH     = 100;
    localparam int R_LOGIC     = 60;
    localparam int R_SHIFT     = 60;
    localparam int MULT_ROUNDS = 20;
    localparam int MOVE_ROUNDS = 10;
    localparam int R_ROUTE     = 40;
    localparam int ISSUES      = 2 + R_ARITH + 30 + R_LOGIC + 14 + R_SHIFT + 20
                               + MULT_ROUNDS * 3 + MOVE_ROUNDS * 4 + R_ROUTE;
    localparam int MAX_CYCLES  = ISSUES + 50;

    logic     i_clk = 1'b0;
    logic     i_reset;
    logic     i_valid;
    instr_t   i_instr;
    word_t    i_srca;
    word_t    i_srcb;
    word_t    i_pc;
    logic     o_valid;
    word_t    o_result;
    logic     o_wr_en;
    reg_idx_t o_wr_reg;
    logic     o_overflow;

    word_t      rng_state   = 32'h2364_881a;
    word_t      model_hi    = '0;
    word_t      model_lo    = '0;
    exp_t       pending[$];
    logic [6:0] pick[$];  // {is_rtype, opcode or funct}
    int         cycle_cnt   = 0;
    int         n_issued    = 0;
    int         n_checked   = 0;
    int         n_errors    = 0;
    int         errs_before = 0;

    // Signed limits for add/sub
    word_t corner_a[5] = '{32'h7fff_ffff, 32'h8000_0000, 32'h8000_0000, 32'h7fff_ffff, 32'h0};
    word_t corner_b[5] = '{32'h1, 32'hffff_ffff, 32'h1, 32'hffff_ffff, 32'h8000_0000};

    exec_unit UUT (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_valid    (i_valid),
        .i_instr    (i_instr),
        .i_srca     (i_srca),
        .i_srcb     (i_srcb),
        .i_pc       (i_pc),
        .o_valid    (o_valid),
        .o_result   (o_result),
        .o_wr_en    (o_wr_en),
        .o_wr_reg   (o_wr_reg),
        .o_overflow (o_overflow)
    );

    always #4 i_clk = ~i_clk;

    always @(posedge i_clk) cycle_cnt <= cycle_cnt + 1;

    function automatic word_t rand_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Random register fields around a fixed opcode or funct
    function automatic instr_t encode(input logic [6:0] kind, input word_t r);
        if (kind[6])
            return {OPC_SPECIAL, r[25:6], kind[5:0]};
        return {kind[5:0], r[25:0]};
    endfunction

    task automatic report_value(input string name, input word_t expv, input word_t actv);
        $display("ERR %0t %s expected %h actual %h", $time, name, expv, actv);
        n_errors++;
    endtask

    task automatic check_quiet();
        if (o_valid !== 1'b0)
            report_value("o_valid", 32'd0, 32'(o_valid));
        if (o_wr_en !== 1'b0)
            report_value("o_wr_en", 32'd0, 32'(o_wr_en));
        if (o_overflow !== 1'b0)
            report_value("o_overflow", 32'd0, 32'(o_overflow));
    endtask

    task automatic issue(input logic [6:0] kind, input word_t a, input word_t b, input word_t r);
        exp_t  e;
        word_t pc;
        pc       = rand_word() & 32'hffff_fffc;
        i_instr  = encode(kind, r);
        i_srca   = a;
        i_srcb   = b;
        i_pc     = pc;
        i_valid  = 1'b1;
        e        = ref_execute(i_instr, a, b, pc, model_hi, model_lo);
        e.issued = cycle_cnt;
        pending.push_back(e);
        n_issued++;
        @(negedge i_clk);
    endtask

    task automatic issue_random(input int count);
        logic [6:0] kind;
        for (int i = 0; i < count; i++) begin
            kind = pick[rand_word() % pick.size()];
            issue(kind, rand_word(), rand_word(), rand_word());
        end
    endtask

    task automatic finish_test(input string name);
        i_valid = 1'b0;
        while (pending.size() != 0)
            @(negedge i_clk);
        @(negedge i_clk);
        $display("Test %-22s done, %0d errors", name, n_errors - errs_before);
        errs_before = n_errors;
    endtask

    //////////////////////////////
    // Output compare
    //////////////////////////////
    always @(negedge i_clk) begin : compare
        exp_t e;
        if (o_valid === 1'b1) begin
            if (pending.size() == 0) begin
                $display("%0t: o_valid high with no instruction in flight", $time);
                n_errors++;
            end else begin
                e = pending.pop_front();
                n_checked++;
                if (cycle_cnt != e.issued + 32'd2) begin
                    $display("%0t: output came %0d cycles after issue, not 2",
                             $time, cycle_cnt - e.issued);
                    n_errors++;
                end
                if (o_wr_en !== e.wr_en)
                    report_value("o_wr_en", 32'(e.wr_en), 32'(o_wr_en));
                if (o_overflow !== e.ovf)
                    report_value("o_overflow", 32'(e.ovf), 32'(o_overflow));
                if (e.chk_res && o_result !== e.result)
                    report_value("o_result", e.result, o_result);
                if (e.chk_reg && o_wr_reg !== e.wr_reg)
                    report_value("o_wr_reg", 32'(e.wr_reg), 32'(o_wr_reg));
            end
        end
    end

    initial begin : watchdog
        wait (cycle_cnt >= MAX_CYCLES);
        $display("Timeout after %0d cycles with %0d outputs missing", cycle_cnt, pending.size());
        $display("Errors found");
        $finish;
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////
    initial begin : stimulus
        logic [6:0] kind;
        word_t      a;
        word_t      r;
        logic [4:0] amt;
        i_reset = 1'b1;
        i_valid = 1'b0;
        i_instr = '0;
        i_srca  = '0;
        i_srcb  = '0;
        i_pc    = '0;

        repeat (3) begin
            @(negedge i_clk);
            check_quiet();
        end
        i_reset = 1'b0;
        repeat (2) begin
            @(negedge i_clk);
            check_quiet();
        end
        issue({1'b1, FN_MFHI}, rand_word(), rand_word(), rand_word());
        issue({1'b1, FN_MFLO}, rand_word(), rand_word(), rand_word());
        finish_test("reset and HI/LO clear");

        pick = '{{1'b1, FN_ADD}, {1'b1, FN_ADDU}, {1'b0, OPC_ADDI}, {1'b0, OPC_ADDIU},
                 {1'b1, FN_SUB}, {1'b1, FN_SUBU}};
        issue_random(R_ARITH);
        for (int c = 0; c < 5; c++)
            for (int k = 0; k < pick.size(); k++)
                issue(pick[k], corner_a[c], corner_b[c], corner_b[c]);  // imm = b[15:0]
        finish_test("arithmetic");

        pick = '{{1'b1, FN_AND}, {1'b1, FN_OR}, {1'b1, FN_XOR}, {1'b1, FN_NOR},
                 {1'b0, OPC_ANDI}, {1'b0, OPC_ORI}, {1'b0, OPC_XORI}, {1'b0, OPC_LUI}};
        issue_random(R_LOGIC);
        // Immediates with bit 15 set
        pick = '{{1'b0, OPC_ANDI}, {1'b0, OPC_ORI}, {1'b0, OPC_XORI}, {1'b0, OPC_ADDIU},
                 {1'b0, OPC_SLTI}, {1'b0, OPC_SLTIU}, {1'b0, OPC_LW}};
        for (int k = 0; k < pick.size(); k++) begin
            r = rand_word();
            r[15:0] = 16'hffff;
            issue(pick[k], rand_word(), rand_word(), r);
            r[15:0] = 16'h8001;
            issue(pick[k], rand_word(), rand_word(), r);
        end
        finish_test("logic and immediates");

        pick = '{{1'b1, FN_SLL}, {1'b1, FN_SRL}, {1'b1, FN_SRA}, {1'b1, FN_SLLV},
                 {1'b1, FN_SRLV}, {1'b1, FN_SRAV}, {1'b1, FN_SLT}, {1'b0, OPC_SLTI},
                 {1'b1, FN_SLTU}, {1'b0, OPC_SLTIU}};
        issue_random(R_SHIFT);
        pick = '{{1'b1, FN_SLL}, {1'b1, FN_SRL}, {1'b1, FN_SRA}, {1'b1, FN_SLLV},
                 {1'b1, FN_SRLV}, {1'b1, FN_SRAV}};
        for (int s = 0; s < 2; s++) begin
            amt = (s == 0) ? 5'd0 : 5'd31;
            for (int k = 0; k < pick.size(); k++) begin
                a = rand_word();
                a[4:0] = amt;
                r = rand_word();
                r[10:6] = amt;
                issue(pick[k], a, rand_word(), r);
            end
        end
        pick = '{{1'b1, FN_SLT}, {1'b0, OPC_SLTI}, {1'b1, FN_SLTU}, {1'b0, OPC_SLTIU}};
        for (int k = 0; k < pick.size(); k++) begin
            issue(pick[k], 32'hffff_ffff, 32'h1, 32'h1);
            issue(pick[k], 32'h1, 32'hffff_ffff, 32'hffff_ffff);
        end
        finish_test("shifts and compares");

        for (int i = 0; i < MULT_ROUNDS; i++) begin
            kind = (rand_word() % 2 == 1) ? {1'b1, FN_MULT} : {1'b1, FN_MULTU};
            issue(kind, rand_word(), rand_word(), rand_word());
            issue({1'b1, FN_MFHI}, rand_word(), rand_word(), rand_word());
            issue({1'b1, FN_MFLO}, rand_word(), rand_word(), rand_word());
        end
        for (int i = 0; i < MOVE_ROUNDS; i++) begin
            issue({1'b1, FN_MTHI}, rand_word(), rand_word(), rand_word());
            issue({1'b1, FN_MFHI}, rand_word(), rand_word(), rand_word());
            issue({1'b1, FN_MTLO}, rand_word(), rand_word(), rand_word());
            issue({1'b1, FN_MFLO}, rand_word(), rand_word(), rand_word());
        end
        finish_test("HI/LO");

        // 6'h3f is neither a known opcode nor a known funct
        pick = '{{1'b0, OPC_LW}, {1'b0, OPC_SW}, {1'b0, OPC_JAL}, {1'b0, 6'h3f},
                 {1'b1, 6'h3f}};
        issue_random(R_ROUTE);
        finish_test("routing and latency");

        $display("Issued %0d, checked %0d, error count %0d", n_issued, n_checked, n_errors);
        if (n_errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/exec_unit.sv
`timescale 1ns/10ps
`default_nettype none

module exec_unit (
    input  wire logic               i_clk,
    input  wire logic               i_reset,
    input  wire logic               i_valid,
    input  wire exec_pkg::instr_t   i_instr,
    input  wire exec_pkg::word_t    i_srca,
    input  wire exec_pkg::word_t    i_srcb,
    input  wire exec_pkg::word_t    i_pc,
    output      logic               o_valid,
    output      exec_pkg::word_t    o_result,
    output      logic               o_wr_en,
    output      exec_pkg::reg_idx_t o_wr_reg,
    output      logic               o_overflow
);
    import exec_pkg::*;

    word_t alu_result;
    logic  alu_overflow;
    word_t hilo_result;
    logic  hilo_rd;

    exec_bus_if bus ();

    //////////////////////////////
    // Stage 1 decode
    //////////////////////////////
    instr_decoder u_decoder (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_valid (i_valid),
        .i_instr (i_instr),
        .i_srca  (i_srca),
        .i_srcb  (i_srcb),
        .i_pc    (i_pc),
        .bus     (bus.src)
    );

    //////////////////////////////
    // Stage 2 execute and writeback
    //////////////////////////////
    alu u_alu (
        .bus        (bus.sink),
        .o_result   (alu_result),
        .o_overflow (alu_overflow)
    );

    hilo_unit u_hilo (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .bus           (bus.sink),
        .o_hilo_result (hilo_result),
        .o_hilo_rd     (hilo_rd)
    );

    exec_writeback u_writeback (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .bus           (bus.sink),
        .i_alu_result  (alu_result),
        .i_overflow    (alu_overflow),
        .i_hilo_result (hilo_result),
        .i_hilo_rd     (hilo_rd),
        .o_valid       (o_valid),
        .o_result      (o_result),
        .o_wr_en       (o_wr_en),
        .o_wr_reg      (o_wr_reg),
        .o_overflow    (o_overflow)
    );

endmodule

`default_nettype wire

// File: logic/exec_writeback.sv
`timescale 1ns/10ps
`default_nettype none

module exec_writeback (
    input  wire logic               i_clk,
    input  wire logic               i_reset,
    exec_bus_if.sink                bus,
    input  wire exec_pkg::word_t    i_alu_result,
    input  wire logic               i_overflow,
    input  wire exec_pkg::word_t    i_hilo_result,
    input  wire logic               i_hilo_rd,
    output      logic               o_valid,
    output      exec_pkg::word_t    o_result,
    output      logic               o_wr_en,
    output      exec_pkg::reg_idx_t o_wr_reg,
    output      logic               o_overflow
);
    import exec_pkg::*;

    logic  writes_reg;
    word_t result_sel;

    // Everything except sw, mult/multu, mthi/mtlo and unknown
    assign writes_reg = (|bus.ops) & ~bus.ops[OP_SW] & ~bus.ops[OP_MULT_HI]
                      & ~(bus.ops[OP_MOVE_HILO] & ~i_hilo_rd);
    assign result_sel = i_hilo_rd ? i_hilo_result : i_alu_result;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_valid    <= 1'b0;
            o_wr_en    <= 1'b0;
            o_overflow <= 1'b0;
        end else begin
            o_valid    <= bus.valid;
            o_wr_en    <= bus.valid & writes_reg & ~i_overflow;  // Trap blocks the write
            o_overflow <= bus.valid & i_overflow;
        end
    end

    always_ff @(posedge i_clk) begin
        o_result <= result_sel;
        o_wr_reg <= bus.dest;
    end

endmodule

`default_nettype wire

// File: logic/hilo_unit.sv
`timescale 1ns/10ps
`default_nettype none

module hilo_unit (
    input  wire logic            i_clk,
    input  wire logic            i_reset,
    exec_bus_if.sink             bus,
    output      exec_pkg::word_t o_hilo_result,
    output      logic            o_hilo_rd
);
    import exec_pkg::*;

    word_t       hi;
    word_t       lo;
    logic [63:0] ext_a;
    logic [63:0] ext_b;
    logic [63:0] product;
    logic        do_mult;
    logic        do_move;

    // Sign or zero extend to 64 bits so the low 64 of the product are exact
    assign ext_a   = {{32{bus.is_signed & bus.srca[31]}}, bus.srca};
    assign ext_b   = {{32{bus.is_signed & bus.srcb[31]}}, bus.srcb};
    assign product = ext_a * ext_b;

    assign do_mult = bus.valid & bus.ops[OP_MULT_HI];
    assign do_move = bus.valid & bus.ops[OP_MOVE_HILO];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            hi <= '0;
            lo <= '0;
        end else if (do_mult) begin
            hi <= product[63:32];
            lo <= product[31:0];
        end else if (do_move) begin
            if (bus.hilo_sel == HILO_MTHI)
                hi <= bus.srca;
            if (bus.hilo_sel == HILO_MTLO)
                lo <= bus.srca;
        end
    end

    // Reads see the value before this cycle's update
    assign o_hilo_rd     = do_move & ((bus.hilo_sel == HILO_MFHI) | (bus.hilo_sel == HILO_MFLO));
    assign o_hilo_result = (bus.hilo_sel == HILO_MFHI) ? hi : lo;

endmodule

`default_nettype wire

// File: alu/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu (
    exec_bus_if.sink                bus,
    output      exec_pkg::word_t    o_result,
    output      logic               o_overflow
);
    import exec_pkg::*;

    op_vec_t ops;
    word_t   a;
    word_t   imm32;
    logic    imm_zext;

    assign ops = bus.ops;
    assign a   = bus.srca;

    // Immediate extension
    assign imm_zext = ops[OP_ANDI] | ops[OP_ORI] | ops[OP_XORI];
    always_comb begin
        if (ops[OP_LUI])
            imm32 = {bus.imm16, 16'h0000};
        else if (imm_zext)
            imm32 = {16'h0000, bus.imm16};
        else
            imm32 = {{16{bus.imm16[15]}}, bus.imm16};
    end

    //////////////////////////////
    // Add / subtract
    //////////////////////////////
    logic        arith_sel;
    logic        arith_reg;
    logic        arith_sub;
    word_t       arith_b;
    logic [32:0] sum33;
    logic [32:0] diff33;
    word_t       arith_r;

    assign arith_sel = ops[OP_ADD] | ops[OP_ADDU] | ops[OP_ADDI] | ops[OP_ADDIU]
                     | ops[OP_SUB] | ops[OP_SUBU];
    assign arith_reg = ops[OP_ADD] | ops[OP_ADDU] | ops[OP_SUB] | ops[OP_SUBU];
    assign arith_sub = ops[OP_SUB] | ops[OP_SUBU];
    assign arith_b   = arith_reg ? bus.srcb : imm32;
    assign sum33     = {a[31], a} + {arith_b[31], arith_b};
    assign diff33    = {a[31], a} - {arith_b[31], arith_b};
    assign arith_r   = arith_sub ? diff33[31:0] : sum33[31:0];  // Same bits signed or not

    assign o_overflow = ((ops[OP_ADD] | ops[OP_ADDI]) & (sum33[32] ^ sum33[31]))
                      | (ops[OP_SUB] & (diff33[32] ^ diff33[31]));

    //////////////////////////////
    // Logic
    //////////////////////////////
    logic  logic_sel;
    word_t logic_b;
    word_t logic_r;

    assign logic_sel = ops[OP_AND] | ops[OP_ANDI] | ops[OP_OR] | ops[OP_ORI]
                     | ops[OP_XOR] | ops[OP_XORI] | ops[OP_NOR] | ops[OP_LUI];
    assign logic_b   = imm_zext ? imm32 : bus.srcb;

    always_comb begin
        if (ops[OP_AND] | ops[OP_ANDI])
            logic_r = a & logic_b;
        else if (ops[OP_OR] | ops[OP_ORI])
            logic_r = a | logic_b;
        else if (ops[OP_XOR] | ops[OP_XORI])
            logic_r = a ^ logic_b;
        else if (ops[OP_LUI])
            logic_r = imm32;
        else
            logic_r = ~(a | logic_b);  // nor
    end

    //////////////////////////////
    // Shifts
    //////////////////////////////
    logic   shift_sel;
    logic   shift_var;
    shamt_t shift_amt;
    word_t  shift_r;

    assign shift_var = ops[OP_SLLV] | ops[OP_SRLV] | ops[OP_SRAV];
    assign shift_sel = ops[OP_SLL] | ops[OP_SRL] | ops[OP_SRA] | shift_var;
    assign shift_amt = shift_var ? a[4:0] : bus.shamt;  // rs low 5 bits

    always_comb begin
        if (ops[OP_SLL] | ops[OP_SLLV])
            shift_r = bus.srcb << shift_amt;
        else if (ops[OP_SRL] | ops[OP_SRLV])
            shift_r = bus.srcb >> shift_amt;
        else
            shift_r = $signed(bus.srcb) >>> shift_amt;
    end

    // Compares
    logic  cmp_sel;
    logic  cmp_signed;
    word_t cmp_b;
    logic  cmp_lt;

    assign cmp_sel    = ops[OP_SLT] | ops[OP_SLTI] | ops[OP_SLTU] | ops[OP_SLTIU];
    assign cmp_signed = ops[OP_SLT] | ops[OP_SLTI];
    assign cmp_b      = (ops[OP_SLTI] | ops[OP_SLTIU]) ? imm32 : bus.srcb;
    assign cmp_lt     = cmp_signed ? ($signed(a) < $signed(cmp_b)) : (a < cmp_b);

    // Address and link
    logic  addr_sel;
    word_t addr_r;
    word_t link_r;

    assign addr_sel = ops[OP_LW] | ops[OP_SW];
    assign addr_r   = a + imm32;
    assign link_r   = bus.pc + 32'd8;

    assign o_result = ({32{arith_sel}}   & arith_r)
                    | ({32{logic_sel}}   & logic_r)
                    | ({32{shift_sel}}   & shift_r)
                    | ({32{cmp_sel}}     & {31'd0, cmp_lt})
                    | ({32{addr_sel}}    & addr_r)
                    | ({32{ops[OP_JAL]}} & link_r);

endmodule

`default_nettype wire

// File: logic/instr_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module instr_decoder (
    input  wire logic             i_clk,
    input  wire logic             i_reset,
    input  wire logic             i_valid,
    input  wire exec_pkg::instr_t i_instr,
    input  wire exec_pkg::word_t  i_srca,
    input  wire exec_pkg::word_t  i_srcb,
    input  wire exec_pkg::word_t  i_pc,
    exec_bus_if.src               bus
);
    import exec_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_idx_t   rt;
    reg_idx_t   rd;
    op_vec_t    next_ops;
    reg_idx_t   next_dest;
    logic       next_signed;
    logic [1:0] next_hilo_sel;

    assign opcode = i_instr[31:26];
    assign rt     = i_instr[20:16];
    assign rd     = i_instr[15:11];
    assign funct  = i_instr[5:0];

    //////////////////////////////
    // Decode
    //////////////////////////////
    always_comb begin
        next_ops      = '0;
        next_dest     = '0;  // Unknown, sw, mult, mthi/mtlo
        next_signed   = 1'b0;
        next_hilo_sel = HILO_MFHI;
        case (opcode)
            OPC_SPECIAL: begin
                next_dest = rd;
                case (funct)
                    FN_ADD:   next_ops[OP_ADD]  = 1'b1;
                    FN_ADDU:  next_ops[OP_ADDU] = 1'b1;
                    FN_SUB:   next_ops[OP_SUB]  = 1'b1;
                    FN_SUBU:  next_ops[OP_SUBU] = 1'b1;
                    FN_AND:   next_ops[OP_AND]  = 1'b1;
                    FN_OR:    next_ops[OP_OR]   = 1'b1;
                    FN_XOR:   next_ops[OP_XOR]  = 1'b1;
                    FN_NOR:   next_ops[OP_NOR]  = 1'b1;
                    FN_SLL:   next_ops[OP_SLL]  = 1'b1;
                    FN_SRL:   next_ops[OP_SRL]  = 1'b1;
                    FN_SRA:   next_ops[OP_SRA]  = 1'b1;
                    FN_SLLV:  next_ops[OP_SLLV] = 1'b1;
                    FN_SRLV:  next_ops[OP_SRLV] = 1'b1;
                    FN_SRAV:  next_ops[OP_SRAV] = 1'b1;
                    FN_SLT:   next_ops[OP_SLT]  = 1'b1;
                    FN_SLTU:  next_ops[OP_SLTU] = 1'b1;
                    FN_MULT, FN_MULTU: begin
                        next_ops[OP_MULT_HI] = 1'b1;
                        next_signed          = (funct == FN_MULT);
                        next_dest            = '0;
                    end
                    FN_MFHI, FN_MFLO, FN_MTHI, FN_MTLO: begin
                        next_ops[OP_MOVE_HILO] = 1'b1;
                        case (funct)
                            FN_MFHI: next_hilo_sel = HILO_MFHI;
                            FN_MFLO: next_hilo_sel = HILO_MFLO;
                            FN_MTHI: next_hilo_sel = HILO_MTHI;
                            default: next_hilo_sel = HILO_MTLO;
                        endcase
                        if (funct == FN_MTHI || funct == FN_MTLO)
                            next_dest = '0;  // No GPR write
                    end
                    default: next_dest = '0;
                endcase
            end
            OPC_ADDI:  begin next_ops[OP_ADDI]  = 1'b1; next_dest = rt; end
            OPC_ADDIU: begin next_ops[OP_ADDIU] = 1'b1; next_dest = rt; end
            OPC_SLTI:  begin next_ops[OP_SLTI]  = 1'b1; next_dest = rt; end
            OPC_SLTIU: begin next_ops[OP_SLTIU] = 1'b1; next_dest = rt; end
            OPC_ANDI:  begin next_ops[OP_ANDI]  = 1'b1; next_dest = rt; end
            OPC_ORI:   begin next_ops[OP_ORI]   = 1'b1; next_dest = rt; end
            OPC_XORI:  begin next_ops[OP_XORI]  = 1'b1; next_dest = rt; end
            OPC_LUI:   begin next_ops[OP_LUI]   = 1'b1; next_dest = rt; end
            OPC_LW:    begin next_ops[OP_LW]    = 1'b1; next_dest = rt; end
            OPC_SW:    next_ops[OP_SW] = 1'b1;
            OPC_JAL:   begin next_ops[OP_JAL]   = 1'b1; next_dest = LINK_REG; end
            default:   next_ops = '0;
        endcase
        if (!i_valid)
            next_ops = '0;  // Idle cycles carry no op
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            bus.valid <= 1'b0;
            bus.ops   <= '0;
        end else begin
            bus.valid <= i_valid;
            bus.ops   <= next_ops;
        end
    end

    // Payload
    always_ff @(posedge i_clk) begin
        bus.srca      <= i_srca;
        bus.srcb      <= i_srcb;
        bus.pc        <= i_pc;
        bus.shamt     <= i_instr[10:6];
        bus.imm16     <= i_instr[15:0];
        bus.dest      <= next_dest;
        bus.is_signed <= next_signed;
        bus.hilo_sel  <= next_hilo_sel;
    end

endmodule

`default_nettype wire

// File: common/exec_bus_if.sv
`timescale 1ns/10ps
`default_nettype none

interface exec_bus_if;
    import exec_pkg::*;

    logic       valid;      // One-cycle strobe
    op_vec_t    ops;
    word_t      srca;
    word_t      srcb;
    word_t      pc;
    shamt_t     shamt;
    imm16_t     imm16;
    reg_idx_t   dest;
    logic       is_signed;  // mult vs multu
    logic [1:0] hilo_sel;

    modport src (
        output valid,
        output ops,
        output srca,
        output srcb,
        output pc,
        output shamt,
        output imm16,
        output dest,
        output is_signed,
        output hilo_sel
    );

    modport sink (
        input valid,
        input ops,
        input srca,
        input srcb,
        input pc,
        input shamt,
        input imm16,
        input dest,
        input is_signed,
        input hilo_sel
    );

endinterface

`default_nettype wire

// File: common/exec_pkg.sv
`default_nettype none

package exec_pkg;

    //////////////////////////////
    // Widths
    //////////////////////////////
    typedef logic [31:0] word_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [15:0] imm16_t;

    localparam int NUM_OPS = 29;
    typedef logic [NUM_OPS-1:0] op_vec_t;

    // One-hot positions in op_vec_t
    localparam int OP_ADD       = 0;
    localparam int OP_ADDU      = 1;
    localparam int OP_ADDI      = 2;
    localparam int OP_ADDIU     = 3;
    localparam int OP_SUB       = 4;
    localparam int OP_SUBU      = 5;
    localparam int OP_AND       = 6;
    localparam int OP_ANDI      = 7;
    localparam int OP_OR        = 8;
    localparam int OP_ORI       = 9;
    localparam int OP_XOR       = 10;
    localparam int OP_XORI      = 11;
    localparam int OP_NOR       = 12;
    localparam int OP_LUI       = 13;
    localparam int OP_SLL       = 14;
    localparam int OP_SRL       = 15;
    localparam int OP_SRA       = 16;
    localparam int OP_SLLV      = 17;
    localparam int OP_SRLV      = 18;
    localparam int OP_SRAV      = 19;
    localparam int OP_SLT       = 20;
    localparam int OP_SLTI      = 21;
    localparam int OP_SLTU      = 22;
    localparam int OP_SLTIU     = 23;
    localparam int OP_LW        = 24;
    localparam int OP_SW        = 25;
    localparam int OP_JAL       = 26;
    localparam int OP_MULT_HI   = 27;  // mult and multu
    localparam int OP_MOVE_HILO = 28;  // mfhi/mflo/mthi/mtlo

    // hilo_sel codes
    localparam logic [1:0] HILO_MFHI = 2'd0;
    localparam logic [1:0] HILO_MFLO = 2'd1;
    localparam logic [1:0] HILO_MTHI = 2'd2;
    localparam logic [1:0] HILO_MTLO = 2'd3;

    //////////////////////////////
    // Opcodes and functs
    //////////////////////////////
    localparam logic [5:0] OPC_SPECIAL = 6'b000000;
    localparam logic [5:0] OPC_JAL     = 6'b000011;
    localparam logic [5:0] OPC_ADDI    = 6'b001000;
    localparam logic [5:0] OPC_ADDIU   = 6'b001001;
    localparam logic [5:0] OPC_SLTI    = 6'b001010;
    localparam logic [5:0] OPC_SLTIU   = 6'b001011;
    localparam logic [5:0] OPC_ANDI    = 6'b001100;
    localparam logic [5:0] OPC_ORI     = 6'b001101;
    localparam logic [5:0] OPC_XORI    = 6'b001110;
    localparam logic [5:0] OPC_LUI     = 6'b001111;
    localparam logic [5:0] OPC_LW      = 6'b100011;
    localparam logic [5:0] OPC_SW      = 6'b101011;

    localparam logic [5:0] FN_SLL   = 6'b000000;
    localparam logic [5:0] FN_SRL   = 6'b000010;
    localparam logic [5:0] FN_SRA   = 6'b000011;
    localparam logic [5:0] FN_SLLV  = 6'b000100;
    localparam logic [5:0] FN_SRLV  = 6'b000110;
    localparam logic [5:0] FN_SRAV  = 6'b000111;
    localparam logic [5:0] FN_MFHI  = 6'b010000;
    localparam logic [5:0] FN_MTHI  = 6'b010001;
    localparam logic [5:0] FN_MFLO  = 6'b010010;
    localparam logic [5:0] FN_MTLO  = 6'b010011;
    localparam logic [5:0] FN_MULT  = 6'b011000;
    localparam logic [5:0] FN_MULTU = 6'b011001;
    localparam logic [5:0] FN_ADD   = 6'b100000;
    localparam logic [5:0] FN_ADDU  = 6'b100001;
    localparam logic [5:0] FN_SUB   = 6'b100010;
    localparam logic [5:0] FN_SUBU  = 6'b100011;
    localparam logic [5:0] FN_AND   = 6'b100100;
    localparam logic [5:0] FN_OR    = 6'b100101;
    localparam logic [5:0] FN_XOR   = 6'b100110;
    localparam logic [5:0] FN_NOR   = 6'b100111;
    localparam logic [5:0] FN_SLT   = 6'b101010;
    localparam logic [5:0] FN_SLTU  = 6'b101011;

    localparam reg_idx_t LINK_REG = 5'd31;  // jal target

endpackage

`default_nettype wire
